// File: compile.f
src/lc3b_pkg.sv
src/control_rom.sv
src/regfile.sv
src/alu.sv
src/dataforward.sv
src/mem_control.sv
src/perf_counters.sv
src/cpu_datapath.sv
verif/tb_mem_model.sv
verif/tb_cpu_datapath.sv

// File: Bender.yml
package:
  name: lc3b_pipeline

sources:
  - files:
      - src/lc3b_pkg.sv
      - src/control_rom.sv
      - src/regfile.sv
      - src/alu.sv
      - src/dataforward.sv
      - src/mem_control.sv
      - src/perf_counters.sv
      - src/cpu_datapath.sv
  - target: test
    files:
      - verif/tb_mem_model.sv
      - verif/tb_cpu_datapath.sv

// File: verif/tb_cpu_datapath.sv
`timescale 1ns/1ps

module tb_cpu_datapath;
	import lc3b_pkg::*;

	typedef struct packed {
		logic [2:0] test;
		logic       marker;	// last store of its test
		logic       any;	// only has to be nonzero
		lc3b_word   addr;
		logic [1:0] be;
		lc3b_word   data;
	} store_t;

	localparam lc3b_word poison_addr = 16'h003e;

	logic       clk, i_reset;
	lc3b_word   i_instr, i_mem_rdata, o_instruction_address, o_mem_address, o_write_data;
	logic       i_instruction_response, i_data_response, o_instruction_request;
	logic       o_data_request, o_write_enable, store_fire;
	logic [1:0] o_mem_byte_enable;

	store_t     exp_q [$];
	store_t     head;
	logic       head_ok = 1'b0;
	lc3b_word   mdl_mem [int];
	string      test_names [5] = '{"alu_chain", "load_use", "branches", "byte_stores", "counters"};
	int         stores_per_test [5] = '{2, 2, 3, 4, 3};
	int         test_errors [5] = '{default: 0};
	int         other_errors = 0;
	int         passed = 0;
	int         failed = 0;
	int         cycles = 0;

	cpu_datapath #(
		.mmio_base (16'hfff0)
	) u_cpu_datapath (
		.clk, .i_reset, .i_instr, .i_instruction_response, .i_mem_rdata, .i_data_response,
		.o_instruction_address, .o_mem_byte_enable, .o_mem_address, .o_write_data,
		.o_instruction_request, .o_data_request, .o_write_enable
	);

	tb_mem_model u_mem_model (
		.clk,
		.i_instruction_request  (o_instruction_request),
		.i_instruction_address  (o_instruction_address),
		.i_data_request         (o_data_request),
		.i_write_enable         (o_write_enable),
		.i_byte_enable          (o_mem_byte_enable),
		.i_data_address         (o_mem_address),
		.i_write_data           (o_write_data),
		.o_instr                (i_instr),
		.o_instruction_response (i_instruction_response),
		.o_rdata                (i_mem_rdata),
		.o_data_response        (i_data_response)
	);

	assign store_fire = o_data_request & o_write_enable & i_data_response;

	function automatic lc3b_word model_read(int idx);
		return mdl_mem.exists(idx) ? mdl_mem[idx] : u_mem_model.dmem[idx];
	endfunction

	// in-order execution of the program that fills the expected store queue
	task automatic run_model();
		lc3b_word regs [8];
		logic     reg_any [8];
		lc3b_word pc, w, ea, res, src2;
		lc3b_cc   cc;
		logic     wr, res_any;
		int       branches, taken, test, stores_left, idx;
		store_t   s;
		regs = '{default: '0};
		reg_any = '{default: 1'b0};
		pc = '0;
		cc = 3'b010;
		branches = 0;
		taken = 0;
		test = 0;
		stores_left = stores_per_test[0];
		for (int step = 0; step < 1000; step++) begin
			w = u_mem_model.imem[pc[8:1]];
			src2 = w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]];
			ea = regs[w[8:6]] + {{9{w[5]}}, w[5:0], 1'b0};	// word offset
			wr = 1'b0;
			res_any = 1'b0;
			res = '0;
			pc = pc + 16'd2;
			case (w[15:12])
				4'b0001: begin
					res = regs[w[8:6]] + src2;
					wr = 1'b1;
				end
				4'b0101: begin
					res = regs[w[8:6]] & src2;
					wr = 1'b1;
				end
				4'b1001: begin
					res = ~regs[w[8:6]];
					wr = 1'b1;
				end
				4'b0110: begin
					wr = 1'b1;
					if (ea == 16'hfff0)
						res_any = 1'b1;	// stall count
					else if (ea == 16'hfff2)
						res = 16'(branches);
					else if (ea == 16'hfff4)
						res = 16'(taken);
					else if (ea < 16'hfff0)
						res = model_read(ea[15:1]);
				end
				4'b0111, 4'b0011: begin
					if (w[14]) begin
						s.addr = ea;
						s.be = 2'b11;
						s.data = regs[w[11:9]];
					end else begin
						s.addr = regs[w[8:6]] + {{10{w[5]}}, w[5:0]};	// byte offset
						s.be = s.addr[0] ? 2'b10 : 2'b01;
						s.data = {2{regs[w[11:9]][7:0]}};
					end
					s.any = reg_any[w[11:9]];
					s.test = 3'(test);
					s.marker = (stores_left == 1);
					stores_left--;
					exp_q.push_back(s);
					idx = s.addr[15:1];
					res = model_read(idx);
					if (s.be[0])
						res[7:0] = s.data[7:0];
					if (s.be[1])
						res[15:8] = s.data[15:8];
					mdl_mem[idx] = res;
					if (s.marker) begin
						test++;
						if (test < 5)
							stores_left = stores_per_test[test];
					end
				end
				4'b0000: begin
					ea = pc + {{6{w[8]}}, w[8:0], 1'b0};
					if (|(w[11:9] & cc)) begin
						if (ea == pc - 16'd2)
							break;	// program spins here
						taken++;
						pc = ea;
					end
					branches++;
				end
				default: ;
			endcase
			if (wr) begin
				regs[w[11:9]] = res;
				reg_any[w[11:9]] = res_any;
				cc = res[15] ? 3'b100 : (res == '0 ? 3'b010 : 3'b001);
			end
		end
	endtask

	task automatic load_head();
		head_ok = (exp_q.size() > 0);
		if (head_ok)
			head = exp_q[0];
	endtask

	task automatic finish_run();
		$display("%0d tests passed, %0d tests failed, %0d other errors",
			passed, failed, other_errors);
		if (failed == 0 && other_errors == 0 && exp_q.size() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic report_test(int t);
		if (test_errors[t] == 0) begin
			passed++;
			$display("test %s passed", test_names[t]);
		end else begin
			failed++;
			$display("test %s failed with %0d mismatches", test_names[t], test_errors[t]);
		end
		if (t == 4)
			finish_run();
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		void'($urandom(32'h387fddd0));
		i_reset = 1'b1;
		repeat (2) @(posedge clk);
		run_model();
		load_head();
		repeat (6) @(posedge clk);
		#1 i_reset = 1'b0;
	end

	// 40 cycles for every instruction in the program
	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * u_mem_model.prog_len) begin
			$display("timeout after %0d cycles, the last test never finished", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// retire the head after the checks of this edge have run
	always @(posedge clk) begin : store_track
		logic [2:0] t;
		logic       m;
		if (!i_reset && store_fire && head_ok) begin
			#2;
			t = head.test;
			m = head.marker;
			void'(exp_q.pop_front());
			load_head();
			if (m)
				report_test(t);
		end
	end

	store_expected: assert property (@(posedge clk) disable iff (i_reset)
		store_fire |-> head_ok)
		else begin
			other_errors++;
			$display("store to %h arrived after all expected stores", $sampled(o_mem_address));
		end

	store_value: assert property (@(posedge clk) disable iff (i_reset)
		store_fire && head_ok |-> o_mem_address == head.addr && o_mem_byte_enable == head.be
			&& (head.any ? o_write_data != '0 : o_write_data == head.data))
		else begin
			test_errors[$sampled(head.test)]++;
			$display("mismatch %s expected addr %h be %b data %h actual addr %h be %b data %h",
				test_names[$sampled(head.test)], $sampled(head.addr), $sampled(head.be),
				$sampled(head.data), $sampled(o_mem_address), $sampled(o_mem_byte_enable),
				$sampled(o_write_data));
		end

	no_poison: assert property (@(posedge clk) disable iff (i_reset)
		o_data_request && o_write_enable |-> o_mem_address != poison_addr)
		else begin
			other_errors++;
			$display("a store behind a taken branch reached memory");
		end

	req_held: assert property (@(posedge clk) disable iff (i_reset)
		o_data_request && !i_data_response |=> o_data_request && $stable(o_mem_address)
			&& $stable(o_write_enable) && $stable(o_mem_byte_enable) && $stable(o_write_data))
		else begin
			other_errors++;
			$display("data request changed or dropped while waiting for memory");
		end

	reset_state: assert property (@(posedge clk) $fell(i_reset) |->
		o_instruction_address == '0 && o_instruction_request && !o_data_request
			&& !o_write_enable)
		else begin
			other_errors++;
			$display("ports not in their reset state after reset");
		end

endmodule : tb_cpu_datapath

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
	input  logic               clk,
	input  logic               i_instruction_request,
	input  lc3b_pkg::lc3b_word i_instruction_address,
	input  logic               i_data_request,
	input  logic               i_write_enable,
	input  logic [1:0]         i_byte_enable,
	input  lc3b_pkg::lc3b_word i_data_address,
	input  lc3b_pkg::lc3b_word i_write_data,
	output lc3b_pkg::lc3b_word o_instr,
	output logic               o_instruction_response,
	output lc3b_pkg::lc3b_word o_rdata,
	output logic               o_data_response
);
	import lc3b_pkg::*;

	lc3b_word imem [256];
	lc3b_word dmem [32768];
	int       prog_len = 0;
	int       fetch_wait = -1;	// cycles left, -1 when nothing pending
	int       data_wait = -1;

	function automatic lc3b_word alu_rr(lc3b_opcode op, int dr, int sr1, int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic lc3b_word alu_ri(lc3b_opcode op, int dr, int sr1, int imm5);
		return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm5)};
	endfunction

	function automatic lc3b_word mem_op(lc3b_opcode op, int r, int base, int off6);
		return {op, 3'(r), 3'(base), 6'(off6)};
	endfunction

	function automatic lc3b_word br(int nzp, int off9);
		return {op_br, 3'(nzp), 9'(off9)};
	endfunction

	task automatic put(lc3b_word w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	initial begin
		o_instr                = '0;
		o_instruction_response = 1'b0;
		o_rdata                = '0;
		o_data_response        = 1'b0;
		for (int i = 0; i < 32768; i++)
			dmem[i] = 16'(i * 40503) ^ 16'h5a5a;	// odd multiplier, unique per word
		for (int i = 0; i < 256; i++)
			imem[i] = '0;	// br with no nzp bits, never taken
		// r6 = 0x20 is the data base, r0 = 0
		put(alu_ri(op_and, 6, 6, 0));
		put(alu_ri(op_add, 6, 6, 8));
		put(alu_rr(op_add, 6, 6, 6));
		put(alu_rr(op_add, 6, 6, 6));
		put(alu_ri(op_and, 0, 0, 0));
		// dependent alu chain
		put(alu_ri(op_add, 1, 0, 7));
		put(alu_ri(op_add, 2, 1, -3));
		put(alu_rr(op_add, 3, 2, 1));
		put(alu_ri(op_and, 4, 3, 14));
		put(alu_rr(op_and, 5, 4, 3));
		put(alu_ri(op_not, 5, 5, -1));
		put(alu_rr(op_add, 5, 5, 5));
		put(mem_op(op_str, 3, 6, 0));
		put(mem_op(op_str, 5, 6, 1));
		// load then use
		put(mem_op(op_ldr, 1, 6, 8));
		put(alu_ri(op_add, 2, 1, 5));
		put(mem_op(op_str, 2, 6, 2));
		put(mem_op(op_ldr, 3, 6, 9));
		put(mem_op(op_str, 3, 6, 3));
		// branches, poison store is str r0 to offset 15
		put(alu_ri(op_add, 1, 0, -1));
		put(br(4, 1));
		put(mem_op(op_str, 0, 6, 15));
		put(br(3, 1));	// zp, falls through
		put(mem_op(op_str, 1, 6, 4));
		put(alu_ri(op_add, 2, 0, 0));
		put(br(2, 1));
		put(mem_op(op_str, 0, 6, 15));
		put(br(5, 1));
		put(mem_op(op_str, 2, 6, 5));
		put(alu_ri(op_add, 3, 0, 3));
		put(br(1, 1));
		put(mem_op(op_str, 0, 6, 15));
		put(br(6, 1));
		put(mem_op(op_str, 3, 6, 6));
		// byte stores, then read the merged word back
		put(mem_op(op_ldr, 4, 6, 10));
		put(mem_op(op_stb, 4, 6, 14));
		put(mem_op(op_stb, 4, 6, 19));
		put(mem_op(op_str, 4, 6, 12));
		put(mem_op(op_ldr, 5, 6, 9));
		put(mem_op(op_str, 5, 6, 13));
		// counters at 0xfff0
		put(alu_ri(op_and, 7, 7, 0));
		put(alu_ri(op_add, 7, 7, -16));
		put(mem_op(op_ldr, 1, 7, 1));
		put(mem_op(op_ldr, 2, 7, 2));
		put(mem_op(op_ldr, 3, 7, 0));
		put(mem_op(op_str, 1, 6, 20));
		put(mem_op(op_str, 2, 6, 21));
		put(mem_op(op_str, 3, 6, 22));
		put(br(7, -1));	// spin here
	end

	always @(posedge clk) begin : fetch_side
		logic was;
		#1;
		was = o_instruction_response;
		o_instruction_response = 1'b0;
		if (!i_instruction_request) begin
			fetch_wait = -1;
		end else begin
			if (fetch_wait < 0 || was)
				fetch_wait = $urandom_range(3, 0);	// new request
			else
				fetch_wait = fetch_wait - 1;
			if (fetch_wait == 0) begin
				o_instr = imem[i_instruction_address[8:1]];
				o_instruction_response = 1'b1;
			end
		end
	end

	always @(posedge clk) begin : data_side
		logic was;
		int   idx;
		#1;
		was = o_data_response;
		o_data_response = 1'b0;
		if (!i_data_request) begin
			data_wait = -1;
		end else begin
			if (data_wait < 0 || was)
				data_wait = $urandom_range(3, 0);
			else
				data_wait = data_wait - 1;
			if (data_wait == 0) begin
				idx = i_data_address[15:1];
				o_data_response = 1'b1;
				if (i_write_enable) begin
					if (i_byte_enable[0])
						dmem[idx][7:0] = i_write_data[7:0];
					if (i_byte_enable[1])
						dmem[idx][15:8] = i_write_data[15:8];
				end else begin
					o_rdata = dmem[idx];
				end
			end
		end
	end

endmodule : tb_mem_model

// File: src/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath #(
	parameter lc3b_pkg::lc3b_word mmio_base = 16'hfff0
) (
	input  logic               clk,
	input  logic               i_reset,
	input  lc3b_pkg::lc3b_word i_instr,
	input  logic               i_instruction_response,
	input  lc3b_pkg::lc3b_word i_mem_rdata,
	input  logic               i_data_response,
	output lc3b_pkg::lc3b_word o_instruction_address,
	output logic [1:0]         o_mem_byte_enable,
	output lc3b_pkg::lc3b_word o_mem_address,
	output lc3b_pkg::lc3b_word o_write_data,
	output logic               o_instruction_request,
	output logic               o_data_request,
	output logic               o_write_enable
);
	import lc3b_pkg::*;

	logic       advance, flush, mem_ready, reg_write, mem_rd, mem_wr, mmio_hit;
	lc3b_word   pc, mem_output, mmio_rdata;
	lc3b_cc     cc, wb_cc;

	logic       ifid_valid;
	lc3b_word   ifid_instr, ifid_pc;

	lc3b_opcode id_opcode;
	alu_op      id_aluop;
	logic       id_use_imm, id_load_reg, id_load_cc, id_mem_read, id_mem_write, id_byte, id_branch;
	lc3b_reg    id_src1, id_src2, id_dest;
	lc3b_word   id_reg_a, id_reg_b, id_imm;

	logic       idex_valid, idex_use_imm, idex_load_reg, idex_load_cc;
	logic       idex_mem_read, idex_mem_write, idex_byte, idex_branch;
	alu_op      idex_aluop;
	lc3b_reg    idex_src1, idex_src2, idex_dest;
	lc3b_word   idex_reg_a, idex_reg_b, idex_imm;

	fwd_sel     sel1, sel2, storesel;
	lc3b_word   ex_a, ex_b_reg, ex_b, ex_store, ex_result;

	logic       exmem_valid, exmem_load_reg, exmem_load_cc;
	logic       exmem_mem_read, exmem_mem_write, exmem_byte, exmem_branch;
	lc3b_reg    exmem_dest;
	lc3b_word   exmem_result, exmem_store;

	logic       memwb_valid, memwb_load_reg, memwb_load_cc, memwb_branch;
	lc3b_reg    memwb_dest;	// nzp bits for a branch
	lc3b_word   memwb_result;	// branch target for a branch

	function automatic lc3b_word fwd_mux(input fwd_sel sel, input lc3b_word from_reg,
			input lc3b_word from_mem, input lc3b_word from_wb);
		case (sel)
			fwd_mem: return from_mem;
			fwd_wb:  return from_wb;
			default: return from_reg;
		endcase
	endfunction

	// fetch drops for the flush cycle, a late response then cannot advance
	assign o_instruction_request = ~flush;
	assign o_instruction_address = pc;
	assign advance = i_instruction_response & o_instruction_request & mem_ready;

	always_ff @(posedge clk) begin
		if (i_reset)
			pc <= '0;
		else if (flush)
			pc <= memwb_result;
		else if (advance)
			pc <= pc + 16'd2;	// fall-through fetch
	end

	always_ff @(posedge clk) begin
		if (i_reset || flush) begin
			ifid_valid  <= 1'b0;
			idex_valid  <= 1'b0;
			exmem_valid <= 1'b0;
			memwb_valid <= 1'b0;	// taken branch retires here
		end else if (advance) begin
			ifid_valid  <= 1'b1;
			idex_valid  <= ifid_valid;
			exmem_valid <= idex_valid;
			memwb_valid <= exmem_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ifid_instr      <= i_instr;
			ifid_pc         <= pc;
			idex_aluop      <= id_aluop;
			idex_use_imm    <= id_use_imm;
			idex_load_reg   <= id_load_reg;
			idex_load_cc    <= id_load_cc;
			idex_mem_read   <= id_mem_read;
			idex_mem_write  <= id_mem_write;
			idex_byte       <= id_byte;
			idex_branch     <= id_branch;
			idex_src1       <= id_src1;
			idex_src2       <= id_src2;
			idex_dest       <= id_dest;
			idex_reg_a      <= id_reg_a;
			idex_reg_b      <= id_reg_b;
			idex_imm        <= id_imm;
			exmem_load_reg  <= idex_load_reg;
			exmem_load_cc   <= idex_load_cc;
			exmem_mem_read  <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
			exmem_byte      <= idex_byte;
			exmem_branch    <= idex_branch;
			exmem_dest      <= idex_dest;
			exmem_result    <= ex_result;
			exmem_store     <= ex_store;
			memwb_load_reg  <= exmem_load_reg;
			memwb_load_cc   <= exmem_load_cc;
			memwb_branch    <= exmem_branch;
			memwb_dest      <= exmem_dest;
			memwb_result    <= mem_output;
		end
	end

	control_rom u_control_rom (
		.i_instr       (ifid_instr),
		.o_opcode      (id_opcode),
		.o_aluop       (id_aluop),
		.o_use_imm     (id_use_imm),
		.o_load_reg    (id_load_reg),
		.o_load_cc     (id_load_cc),
		.o_mem_read    (id_mem_read),
		.o_mem_write   (id_mem_write),
		.o_byte_access (id_byte),
		.o_is_branch   (id_branch)
	);

	assign id_dest = ifid_instr[11:9];
	assign id_src1 = ifid_instr[8:6];
	assign id_src2 = id_mem_write ? ifid_instr[11:9] : ifid_instr[2:0];	// store source

	always_comb begin
		case (id_opcode)
			op_add, op_and: id_imm = {{11{ifid_instr[4]}}, ifid_instr[4:0]};
			op_ldr, op_str: id_imm = {{9{ifid_instr[5]}}, ifid_instr[5:0], 1'b0};
			op_stb:         id_imm = {{10{ifid_instr[5]}}, ifid_instr[5:0]};	// byte offset
			op_br:          id_imm = ifid_pc + 16'd2 + {{6{ifid_instr[8]}}, ifid_instr[8:0], 1'b0};
			default:        id_imm = '0;
		endcase
	end

	regfile u_regfile (
		.clk,
		.i_load  (reg_write),
		.i_dest  (memwb_dest),
		.i_src_a (id_src1),
		.i_src_b (id_src2),
		.i_in    (memwb_result),
		.o_reg_a (id_reg_a),
		.o_reg_b (id_reg_b)
	);

	dataforward u_dataforward (
		.i_ex_src1        (idex_src1),
		.i_ex_src2        (idex_src2),
		.i_mem_dest       (exmem_dest),
		.i_wb_dest        (memwb_dest),
		.i_mem_valid_dest (exmem_valid & exmem_load_reg),
		.i_wb_valid_dest  (memwb_valid & memwb_load_reg),
		.o_sel1           (sel1),
		.o_sel2           (sel2),
		.o_storesel       (storesel)
	);

	assign ex_a     = fwd_mux(sel1, idex_reg_a, mem_output, memwb_result);
	assign ex_b_reg = fwd_mux(sel2, idex_reg_b, mem_output, memwb_result);
	assign ex_store = fwd_mux(storesel, idex_reg_b, mem_output, memwb_result);
	assign ex_b     = idex_use_imm ? idex_imm : ex_b_reg;

	alu u_alu (
		.i_aluop (idex_aluop),
		.i_a     (ex_a),
		.i_b     (ex_b),
		.o_f     (ex_result)
	);

	// the memory-stage op is younger than a taken branch
	assign mem_rd = exmem_valid & exmem_mem_read & ~flush;
	assign mem_wr = exmem_valid & exmem_mem_write & ~flush;

	mem_control u_mem_control (
		.clk,
		.i_reset,
		.i_advance         (advance),
		.i_mem_read        (mem_rd),
		.i_mem_write       (mem_wr),
		.i_byte_access     (exmem_byte),
		.i_address         (exmem_result),
		.i_src_data        (exmem_store),
		.i_mem_rdata       (i_mem_rdata),
		.i_mmio_rdata      (mmio_rdata),
		.i_data_response   (i_data_response),
		.i_mmio_hit        (mmio_hit),
		.o_data_request    (o_data_request),
		.o_write_enable    (o_write_enable),
		.o_mem_byte_enable (o_mem_byte_enable),
		.o_mem_address     (o_mem_address),
		.o_write_data      (o_write_data),
		.o_mem_output      (mem_output),
		.o_ready           (mem_ready)
	);

	perf_counters #(
		.mmio_base (mmio_base)
	) u_perf_counters (
		.clk,
		.i_reset,
		.i_advance        (advance),
		.i_stall          (o_instruction_request | o_data_request),
		.i_branch_retired (memwb_valid & memwb_branch),
		.i_mispredict     (flush),
		.i_address        (exmem_result),
		.o_mmio_hit       (mmio_hit),
		.o_mmio_rdata     (mmio_rdata)
	);

	assign wb_cc = memwb_result[15] ? 3'b100 : ((memwb_result == '0) ? 3'b010 : 3'b001);
	assign reg_write = memwb_valid & memwb_load_reg & advance;

	always_ff @(posedge clk) begin
		if (i_reset)
			cc <= 3'b010;
		else if (memwb_valid && memwb_load_cc && advance)
			cc <= wb_cc;
	end

	// not-taken was the guess, so every taken branch flushes
	assign flush = memwb_valid & memwb_branch & (|(memwb_dest & cc));

	no_req_on_flush: assert property (@(posedge clk) disable iff (i_reset)
		flush |-> !o_data_request);

endmodule : cpu_datapath

// File: src/perf_counters.sv
`timescale 1ns/1ps

module perf_counters #(
	parameter lc3b_pkg::lc3b_word mmio_base = 16'hfff0
) (
	input  logic               clk,
	input  logic               i_reset,
	input  logic               i_advance,
	input  logic               i_stall,
	input  logic               i_branch_retired,
	input  logic               i_mispredict,
	input  lc3b_pkg::lc3b_word i_address,
	output logic               o_mmio_hit,
	output lc3b_pkg::lc3b_word o_mmio_rdata
);
	import lc3b_pkg::*;

	lc3b_word stall_count;
	lc3b_word branch_count;
	lc3b_word mispredict_count;
	lc3b_word offset;

	assign o_mmio_hit = (i_address >= mmio_base);
	assign offset     = i_address - mmio_base;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			stall_count      <= '0;
			branch_count     <= '0;
			mispredict_count <= '0;
		end else begin
			if (i_stall && !i_advance)
				stall_count <= stall_count + 16'd1;	// access pending, nothing moved
			// a branch leaves write-back by advance or by its own flush
			if (i_branch_retired && (i_advance || i_mispredict))
				branch_count <= branch_count + 16'd1;
			if (i_mispredict)
				mispredict_count <= mispredict_count + 16'd1;
		end
	end

	always_comb begin
		case (offset)
			16'd0:   o_mmio_rdata = stall_count;
			16'd2:   o_mmio_rdata = branch_count;
			16'd4:   o_mmio_rdata = mispredict_count;
			default: o_mmio_rdata = '0;
		endcase
	end

endmodule : perf_counters

// File: src/mem_control.sv
`timescale 1ns/1ps

module mem_control (
	input  logic               clk,
	input  logic               i_reset,
	input  logic               i_advance,
	input  logic               i_mem_read,
	input  logic               i_mem_write,
	input  logic               i_byte_access,
	input  lc3b_pkg::lc3b_word i_address,
	input  lc3b_pkg::lc3b_word i_src_data,
	input  lc3b_pkg::lc3b_word i_mem_rdata,
	input  lc3b_pkg::lc3b_word i_mmio_rdata,
	input  logic               i_data_response,
	input  logic               i_mmio_hit,
	output logic               o_data_request,
	output logic               o_write_enable,
	output logic [1:0]         o_mem_byte_enable,
	output lc3b_pkg::lc3b_word o_mem_address,
	output lc3b_pkg::lc3b_word o_write_data,
	output lc3b_pkg::lc3b_word o_mem_output,
	output logic               o_ready
);
	import lc3b_pkg::*;

	// s_wait holds an answered access until the pipeline moves
	typedef enum logic {s_idle, s_wait} mem_state_e;

	mem_state_e state, state_next;
	logic       access;
	lc3b_word   rdata_hold;

	assign access         = (i_mem_read | i_mem_write) & ~i_mmio_hit;	// counters answer at once
	assign o_data_request = access & (state == s_idle);
	assign o_write_enable = o_data_request & i_mem_write;
	assign o_mem_address  = i_address;
	assign o_ready        = ~access | (state == s_wait) | i_data_response;

	always_comb begin
		if (i_byte_access) begin
			o_mem_byte_enable = i_address[0] ? 2'b10 : 2'b01;
			o_write_data      = {i_src_data[7:0], i_src_data[7:0]};	// low byte on both lanes
		end else begin
			o_mem_byte_enable = 2'b11;
			o_write_data      = i_src_data;
		end
	end

	always_comb begin
		if (!i_mem_read)
			o_mem_output = i_address;	// alu result passes on to write-back
		else if (i_mmio_hit)
			o_mem_output = i_mmio_rdata;
		else if (state == s_wait)
			o_mem_output = rdata_hold;
		else
			o_mem_output = i_mem_rdata;
	end

	always_comb begin
		state_next = state;
		case (state)
			s_idle: begin
				if (o_data_request && i_data_response && !i_advance)
					state_next = s_wait;	// fetch side still waiting
			end
			s_wait: begin
				if (i_advance)
					state_next = s_idle;
			end
			default: state_next = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset)
			state <= s_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (i_data_response)
			rdata_hold <= i_mem_rdata;
	end

	// a waiting request keeps its address and direction
	req_stable: assert property (@(posedge clk) disable iff (i_reset)
		o_data_request && !i_data_response |=>
			$stable(o_mem_address) && $stable(o_write_enable));

endmodule : mem_control

// File: src/dataforward.sv
`timescale 1ns/1ps

module dataforward (
	input  lc3b_pkg::lc3b_reg i_ex_src1,
	input  lc3b_pkg::lc3b_reg i_ex_src2,
	input  lc3b_pkg::lc3b_reg i_mem_dest,
	input  lc3b_pkg::lc3b_reg i_wb_dest,
	input  logic              i_mem_valid_dest,
	input  logic              i_wb_valid_dest,
	output lc3b_pkg::fwd_sel  o_sel1,
	output lc3b_pkg::fwd_sel  o_sel2,
	output lc3b_pkg::fwd_sel  o_storesel
);
	import lc3b_pkg::*;

	function automatic fwd_sel pick(input lc3b_reg src, input lc3b_reg mem_dest,
			input logic mem_ok, input lc3b_reg wb_dest, input logic wb_ok);
		if (mem_ok && mem_dest == src)
			return fwd_mem;	// younger producer wins
		if (wb_ok && wb_dest == src)
			return fwd_wb;
		return fwd_reg;
	endfunction

	assign o_sel1 = pick(i_ex_src1, i_mem_dest, i_mem_valid_dest, i_wb_dest, i_wb_valid_dest);
	assign o_sel2 = pick(i_ex_src2, i_mem_dest, i_mem_valid_dest, i_wb_dest, i_wb_valid_dest);

	// store data sits on the second read port
	assign o_storesel = pick(i_ex_src2, i_mem_dest, i_mem_valid_dest, i_wb_dest,
		i_wb_valid_dest);

	mem_sel_needs_dest: assert final (i_mem_valid_dest ||
		(o_sel1 != fwd_mem && o_sel2 != fwd_mem && o_storesel != fwd_mem));

endmodule : dataforward

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  lc3b_pkg::alu_op    i_aluop,
	input  lc3b_pkg::lc3b_word i_a,
	input  lc3b_pkg::lc3b_word i_b,
	output lc3b_pkg::lc3b_word o_f
);
	import lc3b_pkg::*;

	always_comb begin
		case (i_aluop)
			alu_add: o_f = i_a + i_b;	// also base + offset for loads and stores
			alu_and: o_f = i_a & i_b;
			alu_not: o_f = ~i_a;
			default: o_f = i_b;
		endcase
	end

	// known operands always give a known result
	f_known: assert final ($isunknown({i_aluop, i_a, i_b}) || !$isunknown(o_f));

endmodule : alu

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               i_load,
	input  lc3b_pkg::lc3b_reg  i_dest,
	input  lc3b_pkg::lc3b_reg  i_src_a,
	input  lc3b_pkg::lc3b_reg  i_src_b,
	input  lc3b_pkg::lc3b_word i_in,
	output lc3b_pkg::lc3b_word o_reg_a,
	output lc3b_pkg::lc3b_word o_reg_b
);
	import lc3b_pkg::*;

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (i_load)
			regs[i_dest] <= i_in;
	end

	// write-through, decode sees what write-back stores this cycle
	assign o_reg_a = (i_load && i_dest == i_src_a) ? i_in : regs[i_src_a];
	assign o_reg_b = (i_load && i_dest == i_src_b) ? i_in : regs[i_src_b];

endmodule : regfile

// File: src/control_rom.sv
`timescale 1ns/1ps

module control_rom (
	input  lc3b_pkg::lc3b_word   i_instr,
	output lc3b_pkg::lc3b_opcode o_opcode,
	output lc3b_pkg::alu_op      o_aluop,
	output logic                 o_use_imm,
	output logic                 o_load_reg,
	output logic                 o_load_cc,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	output logic                 o_byte_access,
	output logic                 o_is_branch
);
	import lc3b_pkg::*;

	assign o_opcode = lc3b_opcode'(i_instr[15:12]);

	always_comb begin
		// anything not listed below falls out as a bubble
		o_aluop       = alu_add;
		o_use_imm     = 1'b0;
		o_load_reg    = 1'b0;
		o_load_cc     = 1'b0;
		o_mem_read    = 1'b0;
		o_mem_write   = 1'b0;
		o_byte_access = 1'b0;
		o_is_branch   = 1'b0;
		case (o_opcode)
			op_add: begin
				o_use_imm  = i_instr[5];	// imm5 form
				o_load_reg = 1'b1;
				o_load_cc  = 1'b1;
			end
			op_and: begin
				o_aluop    = alu_and;
				o_use_imm  = i_instr[5];
				o_load_reg = 1'b1;
				o_load_cc  = 1'b1;
			end
			op_not: begin
				o_aluop    = alu_not;
				o_load_reg = 1'b1;
				o_load_cc  = 1'b1;
			end
			op_ldr: begin
				o_use_imm  = 1'b1;	// base + offset
				o_load_reg = 1'b1;
				o_load_cc  = 1'b1;
				o_mem_read = 1'b1;
			end
			op_str: begin
				o_use_imm   = 1'b1;
				o_mem_write = 1'b1;
			end
			op_stb: begin
				o_use_imm     = 1'b1;
				o_mem_write   = 1'b1;
				o_byte_access = 1'b1;
			end
			op_br: begin
				o_aluop     = alu_passb;	// target was built in decode
				o_use_imm   = 1'b1;
				o_is_branch = 1'b1;
			end
			default: ;
		endcase
	end

endmodule : control_rom

// File: src/lc3b_pkg.sv
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;	// data or address
	typedef logic [2:0]  lc3b_reg;	// register index
	typedef logic [2:0]  lc3b_cc;	// n, z, p

	// standard lc-3b encodings, only the subset this core runs
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_stb = 4'b0011,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_passb	// b operand straight through
	} alu_op;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		fwd_reg,	// value read in decode
		fwd_mem,
		fwd_wb
	} fwd_sel;

endpackage : lc3b_pkg
